// File: source/sch_pkg.sv
// shared widths, encodings and record layouts of the scheduling pipe
// the blocks refer to everything here by scoped name
package sch_pkg;

  // ==============================
  // widths
  // ==============================
  localparam int NUM_LB_CQ = 64;
  localparam int CQ_IDX_W  = 6;
  localparam int CQ_W      = 7;
  localparam int CMP_ID_W  = 4;
  localparam int SN_FID_W  = 12;

  typedef logic [CQ_W-1:0]     cq_t;
  typedef logic [CQ_IDX_W-1:0] cq_idx_t;
  typedef logic [CMP_ID_W-1:0] cmp_id_t;
  typedef logic [SN_FID_W-1:0] sn_fid_t;
  typedef logic [6:0]          qid_t;
  typedef logic [15:0]         lockid_t;

  // ==============================
  // encodings
  // ==============================
  typedef enum logic [1:0] {
    ATOMIC    = 2'd0,
    UNORDERED = 2'd1,
    ORDERED   = 2'd2,
    DIRECTED  = 2'd3
  } qtype_e;

  // only a schedule command carries work
  typedef enum logic [1:0] {
    QED_CMD_SCHED = 2'd0,
    QED_CMD_NOOP  = 2'd1,
    QED_CMD_FLUSH = 2'd2
  } qed_cmd_e;

  // ==============================
  // records
  // ==============================
  // pad_ok is reused as partial parity on the outbound record
  typedef struct packed {
    logic cq_is_ldb;
    logic congestion_management;
    logic write_buffer_optimization;
    logic ignore_cq_depth;
    logic pad_ok;
  } core_flags_t;

  typedef struct packed {
    logic [1:0]  qe_wt;
    lockid_t     lockid;
    logic        ao_v;
    qtype_e      qtype;
    logic [2:0]  qpri;
    qid_t        qid;
    logic [31:0] payload;
  } hcw_t;

  // queue engine pop, covers directed, ordered and unordered
  typedef struct packed {
    qed_cmd_e    cmd;
    cq_t         cq;
    logic [2:0]  qidix;
    core_flags_t flags;
    hcw_t        hcw;
    sn_fid_t     flid;
    sn_fid_t     sn;
    logic [2:0]  reord_mode;
    logic [4:0]  reord_slot;
    logic        parity;
  } qed_sch_t;

  // atomic engine pop
  typedef struct packed {
    cq_t         cq;
    qid_t        qid;
    logic [2:0]  qidix;
    core_flags_t flags;
    hcw_t        hcw;
    sn_fid_t     fid;
    logic        parity;
  } aqed_sch_t;

  typedef struct packed {
    logic       parity;
    qtype_e     qtype;
    logic [2:0] qpri;
    logic [5:0] qid;
    logic       qidix_msb;
    logic [2:0] qidix;
    logic [2:0] reord_mode;
    logic [4:0] reord_slot;
    sn_fid_t    sn_fid;
  } hist_info_t;

  typedef struct packed {
    logic [1:0] qe_wt;
    lockid_t    hid;
    cmp_id_t    cmp_id;
    hist_info_t info;
  } hist_list_t;

  // record carried down P0..P5
  typedef struct packed {
    cq_t         cq;
    core_flags_t flags;
    hcw_t        hcw;
    cmp_id_t     cmp_id;
    logic        hist_v;
    hist_list_t  hist;
    logic        atmsch;
  } sch_state_t;

  typedef struct packed {
    hcw_t        hcw;
    core_flags_t flags;
    cmp_id_t     cmp_id;
    cq_t         cq;
    logic        cq_is_ldb;
    logic        error;
  } outbound_hcw_t;

endpackage

// File: source/sch_ingress.sv
// front of the scheduling pipe
// merges queue engine and atomic engine pops into the P0 record,
// hands out completion IDs and checks ingress parity
`timescale 1ns/1ps
module sch_ingress (
  input  logic                hqm_gated_clk,
  input  logic                hqm_gated_rst_b,
  input  logic                qed_sch_pop,
  input  sch_pkg::qed_sch_t   qed_sch_data,
  input  logic                aqed_sch_pop,
  input  sch_pkg::aqed_sch_t  aqed_sch_data,
  output logic                p0_v,
  output sch_pkg::sch_state_t p0_state,
  output sch_pkg::sn_fid_t    p0_fid,
  output logic                err_ingress_parity
);

  logic                pop_any;
  logic                qed_sched;
  logic                qed_lb;
  logic                hist_take;
  logic                qed_par;
  logic                aqed_par;
  sch_pkg::hcw_t       src_hcw;
  sch_pkg::core_flags_t src_flags;
  sch_pkg::cmp_id_t    cmp_id_q;
  sch_pkg::cmp_id_t    cmp_id_nxt;
  sch_pkg::sch_state_t p0_nxt;
  sch_pkg::sn_fid_t    fid_nxt;

  // the four flag bits covered by ingress parity
  function automatic logic [3:0] flag_bits(sch_pkg::core_flags_t f);
    return {f.cq_is_ldb, f.congestion_management, f.write_buffer_optimization,
            f.ignore_cq_depth};
  endfunction

  assign pop_any   = qed_sch_pop | aqed_sch_pop;
  assign qed_sched = qed_sch_pop & (qed_sch_data.cmd == sch_pkg::QED_CMD_SCHED);
  assign qed_lb    = qed_sched & qed_sch_data.flags.cq_is_ldb;
  // load-balanced work gets a completion ID and a history entry
  assign hist_take = qed_lb | aqed_sch_pop;

  // pops are exclusive, so one source mux serves both
  assign src_hcw   = qed_sch_pop ? qed_sch_data.hcw : aqed_sch_data.hcw;
  assign src_flags = qed_sch_pop ? qed_sch_data.flags : aqed_sch_data.flags;

  // ==============================
  // ingress parity
  // ==============================
  // odd parity, an even count of ones is an error
  assign qed_par  = ^{qed_sch_data.parity, qed_sch_data.cq, qed_sch_data.qidix,
                      flag_bits(qed_sch_data.flags)};
  assign aqed_par = ^{aqed_sch_data.parity, aqed_sch_data.cq, aqed_sch_data.qidix,
                      flag_bits(aqed_sch_data.flags)};

  assign err_ingress_parity = (qed_sched & ~qed_par) | (aqed_sch_pop & ~aqed_par);

  // ==============================
  // P0 record
  // ==============================
  always_comb begin
    p0_nxt     = '0;
    cmp_id_nxt = cmp_id_q;
    fid_nxt    = qed_sch_pop ? qed_sch_data.flid : aqed_sch_data.fid;

    // noop and flush leave the record zeroed
    if (qed_sched | aqed_sch_pop) begin
      p0_nxt.cq    = qed_sch_pop ? qed_sch_data.cq : aqed_sch_data.cq;
      p0_nxt.flags = src_flags;
      p0_nxt.hcw   = src_hcw;
    end

    if (hist_take) begin
      p0_nxt.cmp_id              = cmp_id_q;
      cmp_id_nxt                 = cmp_id_q + 1'b1;
      p0_nxt.hist_v              = 1'b1;
      p0_nxt.hist.qe_wt          = src_hcw.qe_wt;
      p0_nxt.hist.hid            = src_hcw.lockid;
      p0_nxt.hist.cmp_id         = cmp_id_q;
      p0_nxt.hist.info.qtype     = src_hcw.qtype;
      p0_nxt.hist.info.qpri      = src_hcw.qpri;
      p0_nxt.hist.info.qid       = src_hcw.qid[5:0];
      p0_nxt.hist.info.qidix_msb = src_flags.ignore_cq_depth;
    end

    if (qed_lb) begin
      p0_nxt.hist.info.qidix      = qed_sch_data.qidix;
      p0_nxt.hist.info.reord_mode = qed_sch_data.reord_mode;
      p0_nxt.hist.info.reord_slot = qed_sch_data.reord_slot;
      // ordered traffic tracks the sequence number, the rest the lock ID
      if ((src_hcw.qtype == sch_pkg::ORDERED) |
          ((src_hcw.qtype == sch_pkg::ATOMIC) & src_hcw.ao_v)) begin
        p0_nxt.hist.info.sn_fid = qed_sch_data.sn;
      end else begin
        p0_nxt.hist.info.sn_fid = src_hcw.lockid[sch_pkg::SN_FID_W-1:0];
      end
    end

    if (aqed_sch_pop) begin
      p0_nxt.atmsch           = 1'b1;
      p0_nxt.hist.info.qidix  = aqed_sch_data.qidix;
      p0_nxt.hist.info.sn_fid = aqed_sch_data.fid;
    end
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      p0_v     <= 1'b0;
      cmp_id_q <= '0;
    end else begin
      p0_v     <= pop_any;
      cmp_id_q <= cmp_id_nxt;
    end
  end

  always_ff @(posedge hqm_gated_clk) begin
    if (pop_any) begin
      p0_state <= p0_nxt;
      p0_fid   <= fid_nxt;
    end
  end

endmodule

// File: source/hist_list_push.sv
// history list push from the P0 stage
// picks list, list_a or both per CQ and builds the entries with parity
`timescale 1ns/1ps
module hist_list_push (
  input  logic                          hqm_gated_clk,
  input  logic                          hqm_gated_rst_b,
  input  logic                          p0_v,
  input  sch_pkg::sch_state_t           p0_state,
  input  sch_pkg::sn_fid_t              p0_fid,
  input  logic [sch_pkg::NUM_LB_CQ-1:0] hist_list_mode,
  output logic                          hist_list_push,
  output sch_pkg::cq_idx_t              hist_list_fifo_num,
  output sch_pkg::hist_list_t           hist_list_data,
  output logic                          hist_list_a_push,
  output sch_pkg::cq_idx_t              hist_list_a_fifo_num,
  output sch_pkg::hist_list_t           hist_list_a_data
);

  sch_pkg::cq_idx_t              idx;
  logic                          push_req;
  logic                          ao_atm;
  // per CQ, set means the next alternating push goes to list_a
  logic [sch_pkg::NUM_LB_CQ-1:0] sel_q;
  logic [sch_pkg::NUM_LB_CQ-1:0] sel_nxt;
  sch_pkg::hist_list_t           list_body;
  sch_pkg::hist_list_t           list_a_body;

  // odd parity over the info fields with the parity bit itself cleared
  function automatic logic info_parity(sch_pkg::hist_info_t info);
    sch_pkg::hist_info_t body;
    body        = info;
    body.parity = 1'b0;
    return ~(^body);
  endfunction

  assign idx      = p0_state.cq[sch_pkg::CQ_IDX_W-1:0];
  assign push_req = p0_v & p0_state.hist_v;
  assign ao_atm   = (p0_state.hcw.qtype == sch_pkg::ATOMIC) & p0_state.hcw.ao_v;

  // ==============================
  // list selection
  // ==============================
  always_comb begin
    sel_nxt          = sel_q;
    hist_list_push   = 1'b0;
    hist_list_a_push = 1'b0;
    if (hist_list_mode[idx]) begin
      // alternating mode, one entry per schedule
      if (push_req) begin
        hist_list_push   = ~sel_q[idx];
        hist_list_a_push = sel_q[idx];
        sel_nxt[idx]     = ~sel_q[idx];
      end
    end else begin
      // atomic with ao_v also lands on list_a
      hist_list_push   = push_req;
      hist_list_a_push = push_req & ao_atm;
    end
  end

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      sel_q <= '0;
    end else begin
      sel_q <= sel_nxt;
    end
  end

  // ==============================
  // push payloads
  // ==============================
  always_comb begin
    list_body   = p0_state.hist;
    list_a_body = p0_state.hist;
    if (ao_atm) begin
      list_body.info.qtype    = sch_pkg::ORDERED;
      list_a_body.info.sn_fid = p0_fid;
    end
  end

  always_comb begin
    hist_list_data             = list_body;
    hist_list_data.info.parity = info_parity(list_body.info);
  end

  always_comb begin
    hist_list_a_data             = list_a_body;
    hist_list_a_data.info.parity = info_parity(list_a_body.info);
  end

  // fifo number is the CQ within the multi-FIFO
  assign hist_list_fifo_num   = idx;
  assign hist_list_a_fifo_num = idx;

endmodule

// File: source/sch_drain_pipe.sv
// stages P1 to P5 of the scheduling pipe
// carries records to the outbound drain FIFO push and reports pipe idle
`timescale 1ns/1ps
module sch_drain_pipe (
  input  logic                   hqm_gated_clk,
  input  logic                   hqm_gated_rst_b,
  input  logic                   p0_v,
  input  sch_pkg::sch_state_t    p0_state,
  input  logic                   hist_list_of,
  input  logic                   hist_list_a_of,
  output logic                   outbound_push,
  output sch_pkg::outbound_hcw_t outbound_data,
  output logic                   pipe_idle
);

  // stage valids, bit n is Pn
  logic [5:1]          v_q;
  sch_pkg::sch_state_t st_q [1:5];
  // overflow seen while the P5 record moved in
  logic                err_q;

  always_ff @(posedge hqm_gated_clk or negedge hqm_gated_rst_b) begin
    if (!hqm_gated_rst_b) begin
      v_q <= '0;
    end else begin
      v_q <= {v_q[4:1], p0_v};
    end
  end

  // records only move behind a valid, idle stages keep stale data
  always_ff @(posedge hqm_gated_clk) begin
    if (p0_v) begin
      st_q[1] <= p0_state;
    end
    for (int i = 2; i <= 5; i++) begin
      if (v_q[i-1]) begin
        st_q[i] <= st_q[i-1];
      end
    end
    if (v_q[4]) begin
      err_q <= hist_list_of | hist_list_a_of;
    end
  end

  // ==============================
  // P5 outbound push
  // ==============================
  always_comb begin
    outbound_data.hcw       = st_q[5].hcw;
    outbound_data.flags     = st_q[5].flags;
    outbound_data.cmp_id    = st_q[5].cmp_id;
    outbound_data.cq        = st_q[5].cq;
    outbound_data.cq_is_ldb = st_q[5].flags.cq_is_ldb;
    outbound_data.error     = err_q;
    // partial parity rides in the pad_ok slot, odd
    outbound_data.flags.pad_ok = ~(^{st_q[5].cq, st_q[5].flags.cq_is_ldb, err_q,
                                     st_q[5].cmp_id});
  end

  assign outbound_push = v_q[5];
  assign pipe_idle     = ~p0_v & ~(|v_q);

endmodule

// File: source/sch_pipe_top.sv
// top of the scheduling pipe
// ingress feeds P0, the history push and the drain stages both read it
`timescale 1ns/1ps
module sch_pipe_top (
  input  logic                          hqm_gated_clk,
  input  logic                          hqm_gated_rst_b,
  input  logic                          qed_sch_pop,
  input  sch_pkg::qed_sch_t             qed_sch_data,
  input  logic                          aqed_sch_pop,
  input  sch_pkg::aqed_sch_t            aqed_sch_data,
  output logic                          err_ingress_parity,
  input  logic [sch_pkg::NUM_LB_CQ-1:0] hist_list_mode,
  output logic                          hist_list_push,
  output sch_pkg::cq_idx_t              hist_list_fifo_num,
  output sch_pkg::hist_list_t           hist_list_data,
  output logic                          hist_list_a_push,
  output sch_pkg::cq_idx_t              hist_list_a_fifo_num,
  output sch_pkg::hist_list_t           hist_list_a_data,
  input  logic                          hist_list_of,
  input  logic                          hist_list_a_of,
  output logic                          outbound_push,
  output sch_pkg::outbound_hcw_t        outbound_data,
  output logic                          pipe_idle
);

  // P0 stage shared by both consumers
  logic                p0_v;
  sch_pkg::sch_state_t p0_state;
  sch_pkg::sn_fid_t    p0_fid;

  sch_ingress ingress_i (
    .hqm_gated_clk      (hqm_gated_clk),
    .hqm_gated_rst_b    (hqm_gated_rst_b),
    .qed_sch_pop        (qed_sch_pop),
    .qed_sch_data       (qed_sch_data),
    .aqed_sch_pop       (aqed_sch_pop),
    .aqed_sch_data      (aqed_sch_data),
    .p0_v               (p0_v),
    .p0_state           (p0_state),
    .p0_fid             (p0_fid),
    .err_ingress_parity (err_ingress_parity)
  );

  hist_list_push hist_push_i (
    .hqm_gated_clk        (hqm_gated_clk),
    .hqm_gated_rst_b      (hqm_gated_rst_b),
    .p0_v                 (p0_v),
    .p0_state             (p0_state),
    .p0_fid               (p0_fid),
    .hist_list_mode       (hist_list_mode),
    .hist_list_push       (hist_list_push),
    .hist_list_fifo_num   (hist_list_fifo_num),
    .hist_list_data       (hist_list_data),
    .hist_list_a_push     (hist_list_a_push),
    .hist_list_a_fifo_num (hist_list_a_fifo_num),
    .hist_list_a_data     (hist_list_a_data)
  );

  sch_drain_pipe drain_i (
    .hqm_gated_clk   (hqm_gated_clk),
    .hqm_gated_rst_b (hqm_gated_rst_b),
    .p0_v            (p0_v),
    .p0_state        (p0_state),
    .hist_list_of    (hist_list_of),
    .hist_list_a_of  (hist_list_a_of),
    .outbound_push   (outbound_push),
    .outbound_data   (outbound_data),
    .pipe_idle       (pipe_idle)
  );

endmodule

// File: tests/sch_pipe_model.svh
// reference model of the scheduling pipe, history entries and outbound records
// included inside the testbench module, uses only sch_pkg types
`ifndef SCH_PIPE_MODEL_SVH
`define SCH_PIPE_MODEL_SVH

// parity bit that gives an odd count over cq, qidix and the four flags
function automatic logic ingress_good_parity(sch_pkg::cq_t cq, logic [2:0] qidix,
                                             sch_pkg::core_flags_t f);
  return ($countones({cq, qidix, f.cq_is_ldb, f.congestion_management,
                      f.write_buffer_optimization, f.ignore_cq_depth}) % 2) == 0;
endfunction

// history entry of a load-balanced queue engine schedule, parity still open
function automatic sch_pkg::hist_list_t qed_hist_base(sch_pkg::qed_sch_t d,
                                                      sch_pkg::cmp_id_t id);
  sch_pkg::hist_list_t e;
  e                 = '0;
  e.qe_wt           = d.hcw.qe_wt;
  e.hid             = d.hcw.lockid;
  e.cmp_id          = id;
  e.info.qtype      = d.hcw.qtype;
  e.info.qpri       = d.hcw.qpri;
  e.info.qid        = d.hcw.qid[5:0];
  e.info.qidix_msb  = d.flags.ignore_cq_depth;
  e.info.qidix      = d.qidix;
  e.info.reord_mode = d.reord_mode;
  e.info.reord_slot = d.reord_slot;
  // sequence number for ordered work, lock ID otherwise
  if (d.hcw.qtype == sch_pkg::ORDERED || (d.hcw.qtype == sch_pkg::ATOMIC && d.hcw.ao_v)) begin
    e.info.sn_fid = d.sn;
  end else begin
    e.info.sn_fid = d.hcw.lockid[11:0];
  end
  return e;
endfunction

// atomic engine pops carry no reorder info, sn_fid is the flow ID
function automatic sch_pkg::hist_list_t aqed_hist_base(sch_pkg::aqed_sch_t d,
                                                       sch_pkg::cmp_id_t id);
  sch_pkg::hist_list_t e;
  e                = '0;
  e.qe_wt          = d.hcw.qe_wt;
  e.hid            = d.hcw.lockid;
  e.cmp_id         = id;
  e.info.qtype     = d.hcw.qtype;
  e.info.qpri      = d.hcw.qpri;
  e.info.qid       = d.hcw.qid[5:0];
  e.info.qidix_msb = d.flags.ignore_cq_depth;
  e.info.qidix     = d.qidix;
  e.info.sn_fid    = d.fid;
  return e;
endfunction

function automatic sch_pkg::hist_list_t seal_hist(sch_pkg::hist_list_t e);
  sch_pkg::hist_list_t s;
  s             = e;
  s.info.parity = 1'b0;
  s.info.parity = ($countones(s.info) % 2) == 0;
  return s;
endfunction

// list entry, atomic with ao_v is recorded as ordered
function automatic sch_pkg::hist_list_t list_entry(sch_pkg::hist_list_t base, logic ao_atm);
  sch_pkg::hist_list_t e;
  e = base;
  if (ao_atm) begin
    e.info.qtype = sch_pkg::ORDERED;
  end
  return seal_hist(e);
endfunction

// list_a entry, atomic with ao_v tracks the flow ID
function automatic sch_pkg::hist_list_t list_a_entry(sch_pkg::hist_list_t base, logic ao_atm,
                                                     sch_pkg::sn_fid_t fid);
  sch_pkg::hist_list_t e;
  e = base;
  if (ao_atm) begin
    e.info.sn_fid = fid;
  end
  return seal_hist(e);
endfunction

function automatic sch_pkg::outbound_hcw_t outbound_base(sch_pkg::cq_t cq,
                                                         sch_pkg::core_flags_t flags,
                                                         sch_pkg::hcw_t hcw,
                                                         sch_pkg::cmp_id_t id);
  sch_pkg::outbound_hcw_t r;
  r           = '0;
  r.hcw       = hcw;
  r.flags     = flags;
  r.cmp_id    = id;
  r.cq        = cq;
  r.cq_is_ldb = flags.cq_is_ldb;
  return r;
endfunction

// error and partial parity are known only one cycle before the push
function automatic sch_pkg::outbound_hcw_t outbound_final(sch_pkg::outbound_hcw_t rec,
                                                          logic err);
  sch_pkg::outbound_hcw_t r;
  r              = rec;
  r.error        = err;
  r.flags.pad_ok = ($countones({rec.cq, rec.cq_is_ldb, err, rec.cmp_id}) % 2) == 0;
  return r;
endfunction

`endif

// File: tests/tb_sch_pipe.sv
// testbench of the scheduling pipe top level
// random pops from both engines, checked cycle by cycle against a model
`timescale 1ns/1ps
module tb_sch_pipe;

  logic                          hqm_gated_clk;
  logic                          hqm_gated_rst_b;
  logic                          qed_sch_pop;
  sch_pkg::qed_sch_t             qed_sch_data;
  logic                          aqed_sch_pop;
  sch_pkg::aqed_sch_t            aqed_sch_data;
  logic                          err_ingress_parity;
  logic [sch_pkg::NUM_LB_CQ-1:0] hist_list_mode;
  logic                          hist_list_push;
  sch_pkg::cq_idx_t              hist_list_fifo_num;
  sch_pkg::hist_list_t           hist_list_data;
  logic                          hist_list_a_push;
  sch_pkg::cq_idx_t              hist_list_a_fifo_num;
  sch_pkg::hist_list_t           hist_list_a_data;
  logic                          hist_list_of;
  logic                          hist_list_a_of;
  logic                          outbound_push;
  sch_pkg::outbound_hcw_t        outbound_data;
  logic                          pipe_idle;

  int seed;
  int cyc;
  int last_pop;
  int waited;

  // ==============================
  // model state
  // ==============================
  sch_pkg::cmp_id_t              cmp_m;
  logic [sch_pkg::NUM_LB_CQ-1:0] tog_m;
  logic                          p0_hv;
  logic                          p0_ao;
  sch_pkg::cq_idx_t              p0_idx;
  sch_pkg::hist_list_t           p0_list;
  sch_pkg::hist_list_t           p0_list_a;
  logic                          of_prev;
  // expected outbound records and the cycle each one is due
  int                            due_q[$];
  sch_pkg::outbound_hcw_t        rec_q[$];

  `include "sch_pipe_model.svh"

  sch_pipe_top dut_i (
    .hqm_gated_clk        (hqm_gated_clk),
    .hqm_gated_rst_b      (hqm_gated_rst_b),
    .qed_sch_pop          (qed_sch_pop),
    .qed_sch_data         (qed_sch_data),
    .aqed_sch_pop         (aqed_sch_pop),
    .aqed_sch_data        (aqed_sch_data),
    .err_ingress_parity   (err_ingress_parity),
    .hist_list_mode       (hist_list_mode),
    .hist_list_push       (hist_list_push),
    .hist_list_fifo_num   (hist_list_fifo_num),
    .hist_list_data       (hist_list_data),
    .hist_list_a_push     (hist_list_a_push),
    .hist_list_a_fifo_num (hist_list_a_fifo_num),
    .hist_list_a_data     (hist_list_a_data),
    .hist_list_of         (hist_list_of),
    .hist_list_a_of       (hist_list_a_of),
    .outbound_push        (outbound_push),
    .outbound_data        (outbound_data),
    .pipe_idle            (pipe_idle)
  );

  initial begin
    hqm_gated_clk = 1'b0;
    forever #5 hqm_gated_clk = ~hqm_gated_clk;
  end

  task automatic abort_run(input string line);
    $display("%s", line);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  // random inputs on the falling edge, checks 2 ns later while outputs hold
  task automatic run_cycle(input logic allow_pop);
    int                     roll;
    int                     cmd_roll;
    logic                   bad;
    logic                   sched;
    logic                   exp_err;
    logic                   exp_l;
    logic                   exp_a;
    logic                   exp_idle;
    logic [127:0]           rv_q;
    logic [127:0]           rv_a;
    sch_pkg::outbound_hcw_t exp_rec;
    sch_pkg::hist_list_t    base;
    sch_pkg::hcw_t          hcw;
    sch_pkg::sn_fid_t       fid;
    @(negedge hqm_gated_clk);
    cyc++;
    rv_q = {$random(seed), $random(seed), $random(seed), $random(seed)};
    rv_a = {$random(seed), $random(seed), $random(seed), $random(seed)};
    bad = ({$random(seed)} % 20) == 0;
    roll = {$random(seed)} % 10;
    cmd_roll = {$random(seed)} % 8;
    if (!allow_pop) begin
      roll = 0;
    end

    qed_sch_data = rv_q[$bits(sch_pkg::qed_sch_t)-1:0];
    if (cmd_roll == 0) begin
      qed_sch_data.cmd = sch_pkg::QED_CMD_NOOP;
    end else if (cmd_roll == 1) begin
      qed_sch_data.cmd = sch_pkg::QED_CMD_FLUSH;
    end else begin
      qed_sch_data.cmd = sch_pkg::QED_CMD_SCHED;
    end
    // eight CQs that still set every index bit, so the per-CQ toggles get revisited
    qed_sch_data.cq[5:3] = qed_sch_data.cq[2:0];
    if (!qed_sch_data.flags.cq_is_ldb) begin
      qed_sch_data.hcw.qtype = sch_pkg::DIRECTED;
    end else if (qed_sch_data.hcw.qtype == sch_pkg::DIRECTED) begin
      qed_sch_data.hcw.qtype = sch_pkg::ORDERED;
    end
    qed_sch_data.parity = ingress_good_parity(qed_sch_data.cq, qed_sch_data.qidix,
                                              qed_sch_data.flags) ^ bad;

    aqed_sch_data                 = rv_a[$bits(sch_pkg::aqed_sch_t)-1:0];
    aqed_sch_data.cq[5:3]         = aqed_sch_data.cq[2:0];
    aqed_sch_data.flags.cq_is_ldb = 1'b1;
    aqed_sch_data.hcw.qtype       = sch_pkg::ATOMIC;
    aqed_sch_data.parity = ingress_good_parity(aqed_sch_data.cq, aqed_sch_data.qidix,
                                               aqed_sch_data.flags) ^ bad;

    qed_sch_pop    = (roll >= 4) && (roll <= 6);
    aqed_sch_pop   = roll >= 7;
    hist_list_of   = ({$random(seed)} % 8) == 0;
    hist_list_a_of = ({$random(seed)} % 8) == 0;
    if (({$random(seed)} % 40) == 0) begin
      hist_list_mode[{cmd_roll[2:0], cmd_roll[2:0]}] =
        ~hist_list_mode[{cmd_roll[2:0], cmd_roll[2:0]}];
    end
    #2;

    // ==============================
    // checks of this cycle
    // ==============================
    sched = qed_sch_pop ? (qed_sch_data.cmd == sch_pkg::QED_CMD_SCHED) : aqed_sch_pop;
    exp_err = sched && bad;
    assert (err_ingress_parity == exp_err) else begin
      abort_run($sformatf("Mismatch at %0t: err_ingress_parity %b expected %b",
                          $time, err_ingress_parity, exp_err));
    end

    exp_l = 1'b0;
    exp_a = 1'b0;
    if (p0_hv) begin
      if (hist_list_mode[p0_idx]) begin
        exp_l          = ~tog_m[p0_idx];
        exp_a          = tog_m[p0_idx];
        tog_m[p0_idx]  = ~tog_m[p0_idx];
      end else begin
        exp_l = 1'b1;
        exp_a = p0_ao;
      end
    end
    assert (hist_list_push == exp_l && hist_list_a_push == exp_a) else begin
      abort_run($sformatf("Mismatch at %0t: history pushes %b%b expected %b%b", $time,
                          hist_list_push, hist_list_a_push, exp_l, exp_a));
    end
    if (exp_l) begin
      assert (hist_list_fifo_num == p0_idx && hist_list_data == p0_list) else begin
        abort_run($sformatf("Mismatch at %0t: list entry %h fifo %0d expected %h fifo %0d",
                            $time, hist_list_data, hist_list_fifo_num, p0_list, p0_idx));
      end
    end
    if (exp_a) begin
      assert (hist_list_a_fifo_num == p0_idx && hist_list_a_data == p0_list_a) else begin
        abort_run($sformatf("Mismatch at %0t: list_a entry %h fifo %0d expected %h fifo %0d",
                            $time, hist_list_a_data, hist_list_a_fifo_num, p0_list_a, p0_idx));
      end
    end

    if (due_q.size() > 0 && due_q[0] == cyc) begin
      exp_rec = outbound_final(rec_q[0], of_prev);
      due_q.delete(0);
      rec_q.delete(0);
      assert (outbound_push && outbound_data == exp_rec) else begin
        abort_run($sformatf("Mismatch at %0t: outbound push %b data %h expected %h",
                            $time, outbound_push, outbound_data, exp_rec));
      end
    end else begin
      assert (!outbound_push) else begin
        abort_run($sformatf("Mismatch at %0t: outbound push with no record due", $time));
      end
    end

    exp_idle = (cyc - last_pop) > 6;
    assert (pipe_idle == exp_idle) else begin
      abort_run($sformatf("Mismatch at %0t: pipe_idle %b expected %b",
                          $time, pipe_idle, exp_idle));
    end

    // ==============================
    // model update
    // ==============================
    of_prev = hist_list_of | hist_list_a_of;
    p0_hv   = 1'b0;
    base    = '0;
    hcw     = '0;
    fid     = '0;
    exp_rec = '0;
    if (aqed_sch_pop) begin
      exp_rec = outbound_base(aqed_sch_data.cq, aqed_sch_data.flags, aqed_sch_data.hcw, cmp_m);
      base    = aqed_hist_base(aqed_sch_data, cmp_m);
      hcw     = aqed_sch_data.hcw;
      fid     = aqed_sch_data.fid;
      p0_idx  = aqed_sch_data.cq[5:0];
      p0_hv   = 1'b1;
    end else if (qed_sch_pop && sched) begin
      // directed work keeps cmp_id 0 and skips the history lists
      if (qed_sch_data.flags.cq_is_ldb) begin
        base   = qed_hist_base(qed_sch_data, cmp_m);
        hcw    = qed_sch_data.hcw;
        fid    = qed_sch_data.flid;
        p0_idx = qed_sch_data.cq[5:0];
        p0_hv  = 1'b1;
      end
      exp_rec = outbound_base(qed_sch_data.cq, qed_sch_data.flags, qed_sch_data.hcw,
                              p0_hv ? cmp_m : '0);
    end
    if (p0_hv) begin
      p0_ao     = (hcw.qtype == sch_pkg::ATOMIC) && hcw.ao_v;
      p0_list   = list_entry(base, p0_ao);
      p0_list_a = list_a_entry(base, p0_ao, fid);
      cmp_m     = cmp_m + 1'b1;
    end
    if (qed_sch_pop || aqed_sch_pop) begin
      last_pop = cyc;
      due_q.push_back(cyc + 6);
      rec_q.push_back(exp_rec);
    end
  endtask

  initial begin
    seed            = 32'hf26c564d;
    cyc             = 0;
    last_pop        = -100;
    waited          = 0;
    cmp_m           = '0;
    tog_m           = '0;
    p0_hv           = 1'b0;
    p0_ao           = 1'b0;
    p0_idx          = '0;
    p0_list         = '0;
    p0_list_a       = '0;
    of_prev         = 1'b0;
    hqm_gated_rst_b = 1'b0;
    qed_sch_pop     = 1'b0;
    qed_sch_data    = '0;
    aqed_sch_pop    = 1'b0;
    aqed_sch_data   = '0;
    hist_list_of    = 1'b0;
    hist_list_a_of  = 1'b0;
    hist_list_mode  = {$random(seed), $random(seed)};
    repeat (3) @(posedge hqm_gated_clk);
    @(negedge hqm_gated_clk);
    hqm_gated_rst_b = 1'b1;

    for (int n = 0; n < 3000; n++) begin
      run_cycle(1'b1);
    end

    // every record still due must leave before the pipe reports idle
    while (!(pipe_idle && due_q.size() == 0) && waited < 20) begin
      run_cycle(1'b0);
      waited++;
    end
    if (!(pipe_idle && due_q.size() == 0)) begin
      abort_run("Timeout: the pipe did not drain and return to idle");
    end else begin
      $display("TEST RESULT: PASS");
      $finish;
    end
  end

endmodule

// File: sch_pipe_top.f
+incdir+tests
source/sch_pkg.sv
source/sch_ingress.sv
source/hist_list_push.sv
source/sch_drain_pipe.sv
source/sch_pipe_top.sv
tests/tb_sch_pipe.sv

// File: run.sh
#!/bin/sh
# build the scheduling pipe testbench with Verilator, run it, grep the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --timing -f sch_pipe_top.f --top-module tb_sch_pipe \
  -o tb_sch_pipe > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_sch_pipe > sim.log 2>&1
cat sim.log
grep -q "^TEST RESULT: PASS$" sim.log && echo "simulation passed" || {
  echo "simulation failed"
  exit 1
}
